// ==== project.f ====
hdl/fe_pkg.sv
hdl/fe_ctrl.sv
hdl/fe_pc_gen.sv
hdl/fe_predecode.sv
hdl/fe_exe_track.sv
hdl/fe_top.sv
dv/fe_imem_model.sv
dv/fe_tb.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --Mdir obj_dir
TOP   := fe_tb
FLIST := project.f
LOG   := sim.log

.PHONY: all compile run check clean

all: check

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)

check: run
	grep -F -q '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/fe_tb.sv ====
`timescale 1ns/1ns

module fe_tb;

import fe_pkg::*;

localparam int CLK_PERIOD = 4;
localparam int NUM_TESTS = 6;
localparam int BASE = RESET_VECTOR / 4;
localparam arch_width_t REDIRECT_OFFSET = 32'h40;
localparam arch_width_t BRANCH_WORD = 32'h0000_0063;
localparam arch_width_t JAL_WORD = 32'h0000_006f;
localparam arch_width_t JALR_WORD = 32'h0000_0067;

logic clk;
logic reset;
logic branch_taken;
arch_width_t alu_target;
logic dc_stalled;
logic load_hazard_stall;
logic imem_req_valid;
logic imem_req_ready;
arch_width_t imem_req_addr;
logic imem_rsp_valid;
logic imem_rsp_ready;
arch_width_t imem_rsp_data;
arch_width_t inst_dec;
arch_width_t pc_dec;
arch_width_t pc_exe;
logic bubble_dec;
logic move_past_dec_stall;

arch_width_t prog [1024];
arch_width_t obs_pc [$];
arch_width_t obs_inst [$];
arch_width_t last_pc;
logic exe_due;
int errors;
int checks;

fe_top u_dut (.*);
fe_imem_model u_imem (.*);

// backend ALU gives the same target for every flow instruction
assign alu_target = pc_exe + REDIRECT_OFFSET;

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// an instruction leaves decode on a live cycle with no backend stall
// and sits in execute on the next cycle
always @(negedge clk) begin
    if (!reset && exe_due) begin
        check(pc_exe, last_pc, "execute pc");
    end
    exe_due = 1'b0;
    if (!reset && !bubble_dec && !dc_stalled && !load_hazard_stall) begin
        obs_pc.push_back(pc_dec);
        obs_inst.push_back(inst_dec);
        last_pc = pc_dec;
        exe_due = 1'b1;
    end
end

task automatic check(input arch_width_t got, input arch_width_t exp, input string msg);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
endtask

function automatic arch_width_t next_pc(input arch_width_t pc, input arch_width_t inst,
                                        input logic taken);
    if (inst[6:0] == OPC_JAL || inst[6:0] == OPC_JALR) begin
        return pc + REDIRECT_OFFSET;
    end else if (inst[6:0] == OPC_BRANCH && taken) begin
        return pc + REDIRECT_OFFSET;
    end
    return pc + 32'd4;
endfunction

// addi x1, x0, <word index>
task automatic fill_default();
    int i;
    for (i = 0; i < 1024; i++) begin
        prog[i] = {i[11:0], 5'd0, 3'd0, 5'd1, OPC_OP_IMM};
    end
endtask

task automatic restart_dut(input logic taken);
    int i;
    for (i = 0; i < 1024; i++) begin
        u_imem.prog[i] = prog[i];
    end
    @(posedge clk);
    reset <= 1'b1;
    branch_taken <= taken;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    obs_pc.delete();
    obs_inst.delete();
endtask

// walk the program from the reset vector and compare with what decode saw
task automatic compare_decode(input int n, input logic taken);
    arch_width_t pc;
    int k;
    pc = RESET_VECTOR;
    while (obs_pc.size() < n) @(negedge clk);
    for (k = 0; k < n; k++) begin
        check(obs_pc[k], pc, "decode pc");
        check(obs_inst[k], prog[pc[11:2]], "decode instruction");
        pc = next_pc(pc, prog[pc[11:2]], taken);
    end
endtask

task automatic straight_line_fetch();
    fill_default();
    restart_dut(1'b0);
    compare_decode(10, 1'b0);
endtask

task automatic branch_outcome(input logic taken);
    fill_default();
    prog[BASE + 2] = BRANCH_WORD;
    restart_dut(taken);
    compare_decode(6, taken);
endtask

task automatic jal_redirect();
    fill_default();
    prog[BASE + 1] = JAL_WORD;
    restart_dut(1'b0);
    compare_decode(5, 1'b0);
endtask

task automatic dcache_backpressure();
    arch_width_t held;
    int pulses;
    fill_default();
    restart_dut(1'b0);
    while (obs_pc.size() < 3) @(posedge clk);
    @(posedge clk);
    dc_stalled <= 1'b1;
    pulses = 0;
    @(negedge clk);
    // the response in flight is consumed under the stall and flagged once
    while (bubble_dec) begin
        if (move_past_dec_stall) begin
            pulses++;
        end
        @(negedge clk);
    end
    check(pulses, 32'd1, "move_past_dec_stall pulses");
    held = inst_dec;
    repeat (8) begin
        @(negedge clk);
        check(inst_dec, held, "inst_dec under dcache stall");
        check({31'd0, imem_req_valid && imem_req_ready}, 32'd0, "request under dcache stall");
    end
    @(posedge clk);
    dc_stalled <= 1'b0;
    compare_decode(8, 1'b0);
endtask

task automatic mixed_random_program();
    int i;
    int unsigned r;
    logic taken;
    fill_default();
    for (i = BASE; i < 1024; i++) begin
        r = $urandom % 8;
        if (r == 0) begin
            prog[i] = BRANCH_WORD;
        end else if (r == 1) begin
            prog[i] = JAL_WORD;
        end else if (r == 2) begin
            prog[i] = JALR_WORD;
        end
    end
    taken = ($urandom % 2) == 1;
    restart_dut(taken);
    compare_decode(30, taken);
endtask

initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired, tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("*** FAILED ***");
    $finish;
end

initial begin
    void'($urandom(49538));
    reset = 1'b1;
    branch_taken = 1'b0;
    dc_stalled = 1'b0;
    load_hazard_stall = 1'b0;
    errors = 0;
    checks = 0;
    straight_line_fetch();
    branch_outcome(1'b1);
    branch_outcome(1'b0);
    jal_redirect();
    dcache_backpressure();
    mixed_random_program();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

endmodule

// ==== dv/fe_imem_model.sv ====
`timescale 1ns/1ns

module fe_imem_model (
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_req_valid,
    output logic                imem_req_ready,
    input  fe_pkg::arch_width_t imem_req_addr,
    output logic                imem_rsp_valid,
    input  logic                imem_rsp_ready,
    output fe_pkg::arch_width_t imem_rsp_data
);

import fe_pkg::*;

// word array, filled by the testbench, indexed by address bits 11:2
arch_width_t prog [1024];

// extra cycles left before the response shows up
int unsigned wait_cnt;
logic busy;

// one request at a time, so responses come back in request order
assign imem_req_ready = !busy;

always @(posedge clk) begin
    if (reset) begin
        busy <= 1'b0;
        wait_cnt <= 0;
        imem_rsp_valid <= 1'b0;
        imem_rsp_data <= '0;
    end else if (imem_rsp_valid && imem_rsp_ready) begin
        busy <= 1'b0;
        imem_rsp_valid <= 1'b0;
    end else if (busy) begin
        if (wait_cnt == 0) begin
            imem_rsp_valid <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt - 1;
        end
    end else if (imem_req_valid) begin
        busy <= 1'b1;
        wait_cnt <= $urandom % 4;
        imem_rsp_data <= prog[imem_req_addr[11:2]];
    end
end

endmodule

// ==== hdl/fe_top.sv ====
`timescale 1ns/1ns

module fe_top (
    input  logic                clk,
    input  logic                reset,
    // backend
    input  logic                branch_taken,
    input  fe_pkg::arch_width_t alu_target,
    input  logic                dc_stalled,
    input  logic                load_hazard_stall,
    // instruction memory
    output logic                imem_req_valid,
    input  logic                imem_req_ready,
    output fe_pkg::arch_width_t imem_req_addr,
    input  logic                imem_rsp_valid,
    output logic                imem_rsp_ready,
    input  fe_pkg::arch_width_t imem_rsp_data,
    // decode and execute view
    output fe_pkg::arch_width_t inst_dec,
    output fe_pkg::arch_width_t pc_dec,
    output fe_pkg::arch_width_t pc_exe,
    output logic                bubble_dec,
    output logic                move_past_dec_stall
);

import fe_pkg::*;

pc_sel_t pc_sel;
logic pc_we;
pc_sel_t dec_pc_sel;
logic dec_pc_we;
logic branch_inst_dec;
logic jump_inst_dec;
logic branch_inst_exe;
logic jump_inst_exe;

// all port names match the nets above
fe_ctrl u_ctrl (
    .*
);

fe_pc_gen u_pc_gen (
    .*
);

fe_predecode u_predecode (
    .*
);

fe_exe_track u_exe_track (
    .*
);

endmodule

// ==== hdl/fe_exe_track.sv ====
`timescale 1ns/1ns

module fe_exe_track (
    input  logic                clk,
    input  logic                reset,
    input  fe_pkg::arch_width_t pc_dec,
    input  logic                branch_inst_dec,
    input  logic                jump_inst_dec,
    input  logic                bubble_dec,
    input  logic                load_hazard_stall,
    input  logic                dc_stalled,
    output fe_pkg::arch_width_t pc_exe,
    output logic                branch_inst_exe,
    output logic                jump_inst_exe
);

always_ff @(posedge clk) begin
    if (reset) begin
        pc_exe <= '0;
        branch_inst_exe <= 1'b0;
        jump_inst_exe <= 1'b0;
    end else if (!load_hazard_stall && !dc_stalled) begin
        if (bubble_dec) begin
            // zero PC means nothing valid in execute
            pc_exe <= '0;
            branch_inst_exe <= 1'b0;
            jump_inst_exe <= 1'b0;
        end else begin
            pc_exe <= pc_dec;
            branch_inst_exe <= branch_inst_dec;
            jump_inst_exe <= jump_inst_dec;
        end
    end
end

endmodule

// ==== hdl/fe_predecode.sv ====
`timescale 1ns/1ns

module fe_predecode (
    input  logic                clk,
    input  logic                reset,
    input  fe_pkg::arch_width_t imem_req_addr,
    input  logic                imem_rsp_valid,
    input  logic                imem_rsp_ready,
    input  fe_pkg::arch_width_t imem_rsp_data,
    input  logic                bubble_dec,
    input  logic                dc_stalled,
    output fe_pkg::arch_width_t inst_dec,
    output fe_pkg::arch_width_t pc_dec,
    output logic                branch_inst_dec,
    output logic                jump_inst_dec,
    output fe_pkg::pc_sel_t     dec_pc_sel,
    output logic                dec_pc_we
);

import fe_pkg::*;

arch_width_t inst_q;
arch_width_t pc_q;
opcode_t opcode;
logic flow;

// only one request is in flight, so its address is still on the request
// bus when the response is consumed
always_ff @(posedge clk) begin
    if (reset) begin
        inst_q <= NOP_INST;
        pc_q <= '0;
    end else if (imem_rsp_valid && imem_rsp_ready) begin
        inst_q <= imem_rsp_data;
        pc_q <= imem_req_addr;
    end
end

// bubble shows up as a nop, which also clears the flow flags
assign inst_dec = bubble_dec ? NOP_INST : inst_q;
assign pc_dec = pc_q;

assign opcode = opcode_t'(inst_dec[6:0]);
assign branch_inst_dec = (opcode == OPC_BRANCH);
assign jump_inst_dec = (opcode == OPC_JAL) || (opcode == OPC_JALR);
assign flow = branch_inst_dec || jump_inst_dec;

// flow insts hold the PC until execute resolves them
assign dec_pc_sel = flow ? PC_SEL_PC : PC_SEL_INC4;
// only ask for an advance when the inst can leave decode
assign dec_pc_we = !bubble_dec && !flow && !dc_stalled;

endmodule

// ==== hdl/fe_pc_gen.sv ====
`timescale 1ns/1ns

module fe_pc_gen (
    input  logic                clk,
    input  logic                reset,
    input  fe_pkg::pc_sel_t     pc_sel,
    input  logic                pc_we,
    input  fe_pkg::arch_width_t alu_target,
    output fe_pkg::arch_width_t imem_req_addr
);

import fe_pkg::*;

arch_width_t pc;
arch_width_t pc_nxt;

always_comb begin
    case (pc_sel)
        PC_SEL_INC4: pc_nxt = pc + INST_BYTES;
        PC_SEL_ALU: pc_nxt = alu_target;
        default: pc_nxt = pc;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        pc <= RESET_VECTOR;
    end else if (pc_we) begin
        pc <= pc_nxt;
    end
end

// a written PC goes out on the request bus in the same cycle
assign imem_req_addr = pc_we ? pc_nxt : pc;

endmodule

// ==== hdl/fe_ctrl.sv ====
`timescale 1ns/1ns

module fe_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_req_ready,
    input  logic                imem_rsp_valid,
    input  fe_pkg::arch_width_t pc_dec,
    input  fe_pkg::arch_width_t pc_exe,
    input  logic                branch_inst_dec,
    input  logic                jump_inst_dec,
    input  logic                branch_inst_exe,
    input  logic                jump_inst_exe,
    input  logic                branch_taken,
    input  logic                dc_stalled,
    input  logic                load_hazard_stall,
    input  fe_pkg::pc_sel_t     dec_pc_sel,
    input  logic                dec_pc_we,
    output logic                imem_req_valid,
    output logic                imem_rsp_ready,
    output fe_pkg::pc_sel_t     pc_sel,
    output logic                pc_we,
    output logic                bubble_dec,
    output logic                move_past_dec_stall
);

import fe_pkg::*;

typedef enum logic [2:0] {
    RST,
    STEADY,
    STALL_FLOW,
    STALL_IMEM,
    STALL_DC
} stall_state_t;

stall_state_t state;
stall_state_t nx_state;

// PC of the branch or jump that fetch is waiting on
arch_width_t stalled_pc;
logic record_flow;

// request accepted by imem, response not consumed yet
logic inflight;

logic req_fire;
logic rsp_fire;
logic flow_dec;
logic flow_changed;
logic flow_resolved;
logic hold_dec;

assign req_fire = imem_req_valid && imem_req_ready;
assign rsp_fire = imem_rsp_valid && imem_rsp_ready;
assign flow_dec = branch_inst_dec || jump_inst_dec;
assign flow_changed = (branch_taken && branch_inst_exe) || jump_inst_exe;

// backend freezes decode on a dcache miss or a load-use hazard
assign hold_dec = dc_stalled || load_hazard_stall;

// stalled inst reached execute and the backend is free to resolve it
assign flow_resolved = (stalled_pc == pc_exe) && (pc_exe != '0) &&
                       !load_hazard_stall && !dc_stalled;

// decode holds a live instruction only in these two states
assign bubble_dec = !((state == STEADY) || (state == STALL_DC));

always_ff @(posedge clk) begin
    if (reset) begin
        state <= RST;
        inflight <= 1'b0;
        stalled_pc <= '0;
    end else begin
        state <= nx_state;
        if (req_fire) begin
            inflight <= 1'b1;
        end else if (rsp_fire) begin
            inflight <= 1'b0;
        end
        if (record_flow) begin
            stalled_pc <= pc_dec;
        end
    end
end

always_comb begin
    nx_state = state;
    record_flow = 1'b0;
    pc_sel = dec_pc_sel;
    pc_we = 1'b0;
    imem_req_valid = 1'b0;
    imem_rsp_ready = 1'b0;
    move_past_dec_stall = 1'b0;

    case (state)
        RST: begin
            // cold imem at boot, keep asking for the reset vector
            pc_sel = PC_SEL_PC;
            imem_req_valid = 1'b1;
            if (imem_req_ready) begin
                nx_state = STALL_IMEM;
            end
        end

        STEADY, STALL_DC: begin
            if (hold_dec) begin
                // no new requests, decode keeps its instruction
                nx_state = STALL_DC;
            end else if (flow_dec) begin
                // let the flow inst move to execute, bubble behind it
                record_flow = 1'b1;
                nx_state = STALL_FLOW;
            end else begin
                // advance the PC and request it in the same cycle
                pc_we = dec_pc_we;
                imem_req_valid = 1'b1;
                nx_state = STALL_IMEM;
            end
        end

        STALL_FLOW: begin
            if (flow_resolved) begin
                pc_sel = flow_changed ? PC_SEL_ALU : PC_SEL_INC4;
                pc_we = 1'b1;
                imem_req_valid = 1'b1;
                nx_state = STALL_IMEM;
            end
        end

        STALL_IMEM: begin
            // re-issue an unaccepted request unless the backend is stalled
            imem_req_valid = !inflight && !dc_stalled;
            imem_rsp_ready = 1'b1;
            if (rsp_fire) begin
                // the response lands in an empty decode stage even under a dcache stall
                move_past_dec_stall = dc_stalled;
                nx_state = STEADY;
            end
        end

        default: begin
            nx_state = RST;
        end
    endcase
end

endmodule

// ==== hdl/fe_pkg.sv ====
package fe_pkg;

localparam int ARCH_WIDTH = 32;

typedef logic [ARCH_WIDTH-1:0] arch_width_t;

// first fetch address
// a zero PC marks an empty execute stage so this stays non-zero
localparam arch_width_t RESET_VECTOR = 32'h0000_0100;

// fixed 32-bit instructions, no compressed set
localparam arch_width_t INST_BYTES = 32'd4;

// addi x0, x0, 0
localparam arch_width_t NOP_INST = 32'h0000_0013;

// next PC source
typedef enum logic [1:0] {
    PC_SEL_PC = 2'd0,
    PC_SEL_INC4 = 2'd1,
    PC_SEL_ALU = 2'd2
} pc_sel_t;

// major opcodes seen by the front end
typedef enum logic [6:0] {
    OPC_BRANCH = 7'b110_0011,
    OPC_JAL = 7'b110_1111,
    OPC_JALR = 7'b110_0111,
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP = 7'b011_0011
} opcode_t;

endpackage
